// File: mutative_cache.f
+incdir+.
mutative_types.sv
mutative_txn_pkg.sv
mutative_addr_stage.sv
mutative_plru.sv
mutative_tag_stage.sv
mutative_data_stage.sv
mutative_cache.sv
mutative_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f mutative_cache.f --top-module mutative_cache_tb \
    -o mutative_cache_sim
./obj_dir/mutative_cache_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: mutative_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mutative_cache_tb;

    localparam int LATENCY = 3;

    typedef struct packed {
        logic                           rst_first;
        mutative_types::assoc_mode_t    mode;
        logic                           write;
        mutative_types::cache_address_t address;
        mutative_txn_pkg::data_t        wdata;
        logic                           exp_hit;
        logic                           chk_way;
        mutative_types::way_idx_t       exp_way;
        mutative_txn_pkg::data_t        exp_rdata;
    } stim_row_t;

    typedef struct packed {
        int row;
        int due;
    } pending_t;

    logic                          clk = 1'b0;
    logic                          rst = 1'b1;
    mutative_types::assoc_mode_t   setup = mutative_types::mode_dm;
    logic                          req_valid = 1'b0;
    mutative_txn_pkg::cache_req_t  req = '0;
    logic                          resp_valid;
    mutative_txn_pkg::cache_resp_t resp;

    stim_row_t                   rows [$];
    pending_t                    pending [$];
    mutative_txn_pkg::data_t     shadow [logic [15:0]]; // last data written per address
    mutative_types::assoc_mode_t section_mode;
    logic                        section_start = 1'b0;
    integer                      seed = 29821;
    int                          cycles = 0;
    int                          cur_row = 0;
    int                          resets = 0;
    int                          value_errors = 0;
    int                          other_errors = 0;
    int                          watchdog_ns = 0;
    logic                        table_ready = 1'b0;

    mutative_cache mutative_cache_inst (
        .clk        (clk),
        .rst        (rst),
        .setup      (setup),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic start_section(input mutative_types::assoc_mode_t mode);
        section_mode  = mode;
        section_start = 1'b1;
        resets++;
    endtask

    // write, tag, set, expected hit, expected way (-1 leaves it unchecked)
    task automatic add_row(input int write, input int tag, input int set, input int hit,
                           input int way);
        stim_row_t r;
        r.rst_first         = section_start;
        r.mode              = section_mode;
        r.write             = (write != 0);
        r.address.tag       = mutative_types::tag_t'(tag);
        r.address.set_index = mutative_types::set_idx_t'(set);
        r.wdata             = r.write ? $random(seed) : '0;
        r.exp_hit           = (hit != 0);
        r.chk_way           = (way >= 0);
        r.exp_way           = mutative_types::way_idx_t'(way);
        r.exp_rdata         = (r.exp_hit && !r.write) ? shadow[r.address] : '0;
        if (r.write) begin
            shadow[r.address] = r.wdata;
        end
        section_start = 1'b0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        start_section(mutative_types::mode_dm);
        add_row(1, 'h005, 3, 0, 5); // way from tag bits 2:0
        add_row(0, 'h005, 3, 1, 5);
        add_row(1, 'h00d, 3, 0, 5); // same way, other tag
        add_row(0, 'h005, 3, 0, -1);
        add_row(0, 'h00d, 3, 1, 5);
        add_row(1, 'h002, 3, 0, 2);
        add_row(0, 'h00d, 3, 1, 5);

        start_section(mutative_types::mode_8way);
        for (int i = 0; i < 8; i++) begin
            add_row(1, 'h100 + i, 7, 0, i);
        end
        add_row(1, 'h108, 7, 0, 0); // only way 7 left marked
        add_row(0, 'h100, 7, 0, -1);
        add_row(0, 'h101, 7, 1, 1);
        add_row(0, 'h108, 7, 1, 0);
        add_row(0, 'h107, 7, 1, 7);

        start_section(mutative_types::mode_4way);
        add_row(1, 'h201, 9, 0, 4);
        add_row(1, 'h203, 9, 0, 5);
        add_row(1, 'h205, 9, 0, 6);
        add_row(1, 'h207, 9, 0, 7);
        add_row(0, 'h201, 9, 1, 4); // refresh ways 4 and 6
        add_row(0, 'h205, 9, 1, 6);
        add_row(1, 'h209, 9, 0, 5);
        add_row(0, 'h203, 9, 0, -1);
        add_row(0, 'h209, 9, 1, 5);
        add_row(0, 'h201, 9, 1, 4);
        add_row(1, 'h200, 9, 0, 0); // even tags use ways 0 to 3
        add_row(0, 'h207, 9, 1, 7);

        start_section(mutative_types::mode_2way);
        add_row(1, 'h300, 2, 0, 0);
        add_row(1, 'h301, 2, 0, 2);
        add_row(1, 'h304, 2, 0, 1);
        add_row(1, 'h305, 2, 0, 3);
        add_row(1, 'h308, 2, 0, 0); // pair 0/1 only
        add_row(1, 'h303, 2, 0, 6);
        add_row(0, 'h301, 2, 1, 2);
        add_row(0, 'h305, 2, 1, 3);
        add_row(0, 'h300, 2, 0, -1);
        add_row(0, 'h304, 2, 1, 1);
        add_row(0, 'h308, 2, 1, 0);
        add_row(0, 'h303, 2, 1, 6);

        start_section(mutative_types::mode_8way);
        add_row(1, 'h400, 12, 0, 0);
        add_row(0, 'h400, 12, 1, 0);
        add_row(1, 'h400, 12, 1, 0);
        add_row(0, 'h400, 12, 1, 0);
        add_row(1, 'h401, 12, 0, 1);
        add_row(0, 'h401, 12, 1, 1);
        add_row(0, 'h400, 12, 1, 0);
        add_row(1, 'h401, 12, 1, 1);
        add_row(0, 'h401, 12, 1, 1);

        start_section(mutative_types::mode_8way);
        add_row(0, 'h400, 12, 0, -1); // written before the reset
        add_row(0, 'h401, 12, 0, -1);
        add_row(1, 'h400, 12, 0, 0);
        add_row(0, 'h400, 12, 1, 0);
    endtask

    task automatic check_data(input string name, input mutative_txn_pkg::data_t got,
                              input mutative_txn_pkg::data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_way(input string name, input mutative_types::way_idx_t got,
                             input mutative_types::way_idx_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic match_response();
        pending_t  p;
        stim_row_t r;
        if (pending.size() == 0) begin
            other_errors++;
            $display("a response arrived with no request outstanding at cycle %0d", cycles);
        end else begin
            p = pending.pop_front();
            r = rows[p.row];
            if (cycles != p.due) begin
                other_errors++;
                $display("row %0d: response came at cycle %0d instead of cycle %0d",
                         p.row, cycles, p.due);
            end
            if (resp.write !== r.write) begin
                other_errors++;
                $display("row %0d: the response does not echo the request type", p.row);
            end
            if (resp.hit !== r.exp_hit) begin
                other_errors++;
                $display("row %0d: expected a %s but the cache reported a %s", p.row,
                         r.exp_hit ? "hit" : "miss", resp.hit ? "hit" : "miss");
            end
            if (r.chk_way) begin
                check_way($sformatf("resp.way row %0d", p.row), resp.way, r.exp_way);
            end
            check_data($sformatf("resp.rdata row %0d", p.row), resp.rdata, r.exp_rdata);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (resp_valid) begin
            match_response();
        end
        if (req_valid) begin
            pending.push_back('{row: cur_row, due: cycles + LATENCY}); // response edge
        end
    end

    task automatic apply_reset(input mutative_types::assoc_mode_t mode);
        @(posedge clk);
        rst   <= 1'b1;
        setup <= mode; // mode only moves inside reset
        repeat (16) @(posedge clk);
        rst   <= 1'b0;
    endtask

    task automatic report_counts();
        $display("summary: %0d rows, %0d value mismatches, %0d other failures",
                 rows.size(), value_errors, other_errors);
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("timeout: the cache stopped answering before the table was done");
        report_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        mutative_txn_pkg::cache_req_t next_req;
        build_table();
        watchdog_ns = (rows.size() + resets * 24 + 100) * 10;
        table_ready = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].rst_first) begin
                @(posedge clk);
                req_valid <= 1'b0;
                while (pending.size() != 0) @(posedge clk); // drain first
                apply_reset(rows[i].mode);
            end
            next_req.write   = rows[i].write;
            next_req.address = rows[i].address;
            next_req.wdata   = rows[i].wdata;
            @(posedge clk);
            req_valid <= 1'b1;
            req       <= next_req;
            cur_row   <= i;
        end
        @(posedge clk);
        req_valid <= 1'b0;
        while (pending.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mutative_cache.sv
`timescale 1ns/1ps
`default_nettype none

module mutative_cache (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire mutative_types::assoc_mode_t   setup,
    input  wire logic                          req_valid,
    input  wire mutative_txn_pkg::cache_req_t  req,
    output logic                               resp_valid,
    output mutative_txn_pkg::cache_resp_t      resp
);

    mutative_txn_pkg::lookup_t lookup;
    mutative_txn_pkg::access_t access;
    logic                      touch;
    mutative_types::way_idx_t  touch_way;
    mutative_types::way_idx_t  evict_way;
    mutative_types::way_mask_t evict_we;

    mutative_addr_stage addr_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .lookup    (lookup)
    );

    mutative_tag_stage tag_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .setup     (setup),
        .lookup    (lookup),
        .touch     (touch),
        .touch_way (touch_way),
        .evict_way (evict_way),
        .evict_we  (evict_we),
        .access    (access)
    );

    mutative_plru plru_inst (
        .clk           (clk),
        .rst           (rst),
        .setup         (setup),
        .cache_address (lookup.cache_address),
        .touch         (touch),
        .touch_way     (touch_way),
        .evict_way     (evict_way),
        .evict_we      (evict_we)
    );

    mutative_data_stage data_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .access     (access),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// File: mutative_data_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mutative_cfg.svh"

module mutative_data_stage (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire mutative_txn_pkg::access_t   access,
    output logic                             resp_valid,
    output mutative_txn_pkg::cache_resp_t    resp
);

    mutative_txn_pkg::data_t data_array [`MUT_SETS][`MUT_WAYS];

    mutative_txn_pkg::data_t stored;
    logic                    read_hit;
    logic                    do_write;

    assign stored   = data_array[access.set_index][access.way];
    assign read_hit = access.valid && !access.write && access.hit;
    assign do_write = access.valid && access.write; // hit way or victim

    always_ff @(posedge clk) begin
        if (do_write) begin
            data_array[access.set_index][access.way] <= access.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= access.valid;
        end
        resp.write <= access.write;
        resp.hit   <= access.hit;
        resp.way   <= access.way;
        resp.rdata <= read_hit ? stored : '0; // zero on misses and writes
    end

endmodule

`default_nettype wire

// File: mutative_tag_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mutative_cfg.svh"

module mutative_tag_stage (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire mutative_types::assoc_mode_t   setup,
    input  wire mutative_txn_pkg::lookup_t     lookup,
    output logic                               touch,
    output mutative_types::way_idx_t           touch_way,
    input  wire mutative_types::way_idx_t      evict_way,
    input  wire mutative_types::way_mask_t     evict_we,
    output mutative_txn_pkg::access_t          access
);

    mutative_types::tag_t      tag_array [`MUT_SETS][`MUT_WAYS];
    mutative_types::way_mask_t valid_array [`MUT_SETS];

    mutative_types::way_mask_t group;
    mutative_types::way_mask_t hit_vec;
    mutative_types::way_idx_t  hit_way;
    mutative_types::set_idx_t  set;
    mutative_types::tag_t      tag;
    logic                      hit;
    logic                      alloc;

    assign set = lookup.cache_address.set_index;
    assign tag = lookup.cache_address.tag;

    always_comb begin
        group   = mutative_types::group_mask(setup, tag);
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < `MUT_WAYS; w++) begin
            hit_vec[w] = group[w] && valid_array[set][w] && (tag_array[set][w] == tag);
            if (hit_vec[w]) begin
                hit_way = mutative_types::way_idx_t'(w);
            end
        end
    end

    assign hit   = |hit_vec;
    assign alloc = lookup.valid && lookup.write && !hit; // write miss takes the victim

    assign touch     = lookup.valid && (hit || lookup.write);
    assign touch_way = hit ? hit_way : evict_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `MUT_SETS; s++) begin
                valid_array[s] <= '0;
            end
        end else if (alloc) begin
            valid_array[set] <= valid_array[set] | evict_we;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            for (int w = 0; w < `MUT_WAYS; w++) begin
                if (evict_we[w]) begin
                    tag_array[set][w] <= tag;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            access.valid <= 1'b0;
        end else begin
            access.valid <= lookup.valid;
        end
        access.write     <= lookup.write;
        access.hit       <= hit;
        access.way       <= touch_way; // victim on a miss
        access.set_index <= set;
        access.wdata     <= lookup.wdata;
    end

    // a tag is never held twice inside one group
    assert property (@(posedge clk) disable iff (rst) lookup.valid |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: mutative_plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "mutative_cfg.svh"

module mutative_plru (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire mutative_types::assoc_mode_t    setup,
    input  wire mutative_types::cache_address_t cache_address,
    input  wire logic                           touch,
    input  wire mutative_types::way_idx_t       touch_way,
    output mutative_types::way_idx_t            evict_way,
    output mutative_types::way_mask_t           evict_we
);

    // one MRU bit per way and set
    mutative_types::way_mask_t mru [`MUT_SETS];

    mutative_types::set_idx_t  set;
    mutative_types::way_mask_t group;
    mutative_types::way_mask_t zeros;
    mutative_types::way_mask_t candidates;
    mutative_types::way_mask_t touch_bit;
    logic                      saturate;

    assign set       = cache_address.set_index;
    assign group     = mutative_types::group_mask(setup, cache_address.tag);
    assign zeros     = ~mru[set] & group; // ways not used lately
    assign touch_bit = mutative_types::way_mask_t'(1) << touch_way;

    // no zero left means the whole group is fair game
    assign candidates = (zeros != '0) ? zeros : group;

    always_comb begin
        evict_way = '0;
        if (setup == mutative_types::mode_dm) begin
            evict_way = mutative_types::way_idx_t'(cache_address.tag[2:0]);
        end else begin
            for (int w = `MUT_WAYS - 1; w >= 0; w--) begin // lowest wins
                if (candidates[w]) begin
                    evict_way = mutative_types::way_idx_t'(w);
                end
            end
        end
    end

    assign evict_we = mutative_types::way_mask_t'(1) << evict_way;

    // touching the last zero, or a full group
    assign saturate = (zeros == touch_bit) || (zeros == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `MUT_SETS; s++) begin
                mru[s] <= '0;
            end
        end else if (touch) begin
            if (saturate) begin
                mru[set] <= (mru[set] & ~group) | touch_bit; // restart the group
            end else begin
                mru[set] <= mru[set] | touch_bit;
            end
        end
    end

    // victim never carries an MRU mark outside direct-mapped mode
    assert property (@(posedge clk) disable iff (rst)
        touch && (setup != mutative_types::mode_dm) |-> ((evict_we & mru[set]) == '0));

    // associativity only changes across a reset
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $stable(setup));

endmodule

`default_nettype wire

// File: mutative_addr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mutative_addr_stage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         req_valid,
    input  wire mutative_txn_pkg::cache_req_t req,
    output mutative_txn_pkg::lookup_t         lookup
);

    mutative_types::cache_address_t split_address;

    assign split_address = mutative_types::cache_address_t'(req.address); // tag above set

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup.valid <= 1'b0;
        end else begin
            lookup.valid <= req_valid;
        end
        if (req_valid) begin // hold payload between requests
            lookup.write         <= req.write;
            lookup.cache_address <= split_address;
            lookup.wdata         <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: mutative_txn_pkg.sv
`default_nettype none

`include "mutative_cfg.svh"

package mutative_txn_pkg;

    typedef logic [`MUT_DATA_BITS-1:0] data_t;

    typedef struct packed {
        logic                     write;
        logic [`MUT_ADDR_BITS-1:0] address;
        data_t                    wdata;
    } cache_req_t;

    typedef struct packed {
        logic                         valid;
        logic                         write;
        mutative_types::cache_address_t cache_address;
        data_t                        wdata;
    } lookup_t;

    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic                     hit;
        mutative_types::way_idx_t way;
        mutative_types::set_idx_t set_index;
        data_t                    wdata;
    } access_t;

    typedef struct packed {
        logic                     write;
        logic                     hit;
        mutative_types::way_idx_t way;
        data_t                    rdata;
    } cache_resp_t;

endpackage

`default_nettype wire

// File: mutative_types.sv
`default_nettype none

`include "mutative_cfg.svh"

package mutative_types;

    typedef logic [$clog2(`MUT_WAYS)-1:0] way_idx_t;
    typedef logic [`MUT_WAYS-1:0] way_mask_t;
    typedef logic [$clog2(`MUT_SETS)-1:0] set_idx_t;
    typedef logic [`MUT_ADDR_BITS-$clog2(`MUT_SETS)-1:0] tag_t;

    typedef struct packed {
        tag_t     tag;
        set_idx_t set_index;
    } cache_address_t;

    typedef enum logic [1:0] {
        mode_dm   = 2'd0,
        mode_2way = 2'd1,
        mode_4way = 2'd2,
        mode_8way = 2'd3
    } assoc_mode_t;

    // ways open to this tag, low tag bits pick the group
    function automatic way_mask_t group_mask(assoc_mode_t mode, tag_t tag);
        case (mode)
            mode_dm:   return way_mask_t'(1) << tag[2:0];
            mode_2way: return way_mask_t'(2'b11) << {tag[1:0], 1'b0};
            mode_4way: return way_mask_t'(4'hf) << {tag[0], 2'b00};
            default:   return '1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: mutative_cfg.svh
`ifndef MUTATIVE_CFG_SVH
`define MUTATIVE_CFG_SVH

// cache geometry

// physical ways, shared by every mode
`define MUT_WAYS 8

// sets per way
`define MUT_SETS 16

// word address, tag plus set index
`define MUT_ADDR_BITS 16

// data word
`define MUT_DATA_BITS 32

`endif
